/* logic/sync_macros.svh */
`ifndef SYNC_MACROS_SVH
`define SYNC_MACROS_SVH

// port count and datapath widths
`define SYNC_PORT_COUNT      4
`define SYNC_DATA_W          64
`define SYNC_CTRL_W          8
`define SYNC_TIME_W          64
`define SYNC_TS_W            80
`define SYNC_MAC_W           48
`define SYNC_CORR_W          64
`define SYNC_TRAILER_W       48
`define SYNC_INTERVAL_W      16
`define SYNC_TIMEOUT_W       16
`define SYNC_LINK_DELAY_W    32
`define SYNC_BEAT_CNT_W      4

// tick constants, 125 MHz core clock
`define SYNC_TICKS_PER_US    125
`define SYNC_US_CNT_W        7
`define SYNC_NS_PER_TICK     8

// frame shape
`define SYNC_FRAME_BEATS     9
`define SYNC_CTRL_SOF        8'hFF
`define SYNC_CTRL_EOF        8'h01

`define SYNC_RESIDENCE_TICKS 690 // fixed residence in clocks
`define SYNC_FIXED_OFFSET_NS 16

// default header fields sent by the master
`define SYNC_ETHER_TYPE      16'h88F7
`define SYNC_DEF_MAC_D       48'h011B19000000
`define SYNC_DEF_MAC_S       48'h3C970E0F6857
`define SYNC_PTP_VERSION     4'h2
`define SYNC_MSG_LENGTH      16'h002C
`define SYNC_PORT_IDENTITY   80'h0000FF0523456789ABCD
`define SYNC_LOG_INTERVAL    8'h7F

`endif

/* logic/sync_frame_pkg.sv */
`include "sync_macros.svh"

package sync_frame_pkg;

	////////////////////
	// one beat on a port
	////////////////////
	typedef struct packed {
		logic [`SYNC_DATA_W-1:0] data;
		logic [`SYNC_CTRL_W-1:0] ctrl; // SOF on beat 0, EOF on beat 8
		logic                    wr;
	} beat_t;

	////////////////////
	// fields that vary between frames
	////////////////////
	typedef struct packed {
		logic [`SYNC_DATA_W-1:0]    header_stamp; // beat 0
		logic [`SYNC_MAC_W-1:0]     mac_d;
		logic [`SYNC_MAC_W-1:0]     mac_s;
		logic [`SYNC_CORR_W-1:0]    correction;   // beats 3 and 4
		logic [`SYNC_TS_W-1:0]      origin;       // beats 7 and 8
		logic [`SYNC_TRAILER_W-1:0] trailer;      // low part of beat 8
	} sync_fields_t;

	// receive side
	typedef enum logic [1:0] {
		rx_idle,
		rx_granted, // waiting for SOF
		rx_body,
		rx_compute
	} rx_state_e;

	// transmit side
	typedef enum logic [1:0] {
		tx_idle,
		tx_wait_ready,
		tx_send
	} tx_state_e;

endpackage

/* logic/sync_time_pkg.sv */
`include "sync_macros.svh"

package sync_time_pkg;

	// master wins when both enables are set
	typedef enum logic [1:0] {
		role_none,
		role_master,
		role_slave
	} role_e;

	////////////////////
	// arrival time handed to the time keeper
	////////////////////
	typedef struct packed {
		logic                    valid;
		logic [`SYNC_TIME_W-1:0] value; // ns
	} time_load_t;

endpackage

/* logic/sync_tick_gen.sv */
`timescale 1ns/1ps
`include "sync_macros.svh"

module sync_tick_gen (
	input  logic                         clk,
	input  logic                         rst,
	input  sync_time_pkg::role_e         role,
	input  logic [`SYNC_INTERVAL_W-1:0]  sync_interval, // us
	input  logic [`SYNC_TIMEOUT_W-1:0]   sync_timeout,  // intervals
	input  logic                         rx_done,
	output logic                         send_req,
	output logic                         sync_state
);

	localparam logic [`SYNC_US_CNT_W-1:0] us_last = `SYNC_US_CNT_W'(`SYNC_TICKS_PER_US - 1);

	logic [`SYNC_US_CNT_W-1:0]   us_cnt;
	logic                        us_tick;
	logic [`SYNC_INTERVAL_W-1:0] int_cnt;
	logic                        int_done;
	logic                        role_active;
	logic [`SYNC_TIMEOUT_W-1:0]  to_cnt;
	logic [`SYNC_TIMEOUT_W-1:0]  to_next;

	assign us_tick     = (us_cnt == us_last);
	assign int_done    = us_tick && (int_cnt == sync_interval - 1'b1);
	assign role_active = (role != sync_time_pkg::role_none);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			us_cnt  <= '0;
			int_cnt <= '0;
			send_req <= 1'b0;
		end else begin
			us_cnt <= us_tick ? '0 : us_cnt + 1'b1;
			if (!role_active || int_done)
				int_cnt <= '0; // restart interval
			else if (us_tick)
				int_cnt <= int_cnt + 1'b1;
			send_req <= int_done && (role == sync_time_pkg::role_master);
		end
	end

	////////////////////
	// slave timeout
	////////////////////
	always_comb begin
		to_next = to_cnt;
		if (role != sync_time_pkg::role_slave || rx_done)
			to_next = '0;
		else if (int_done && to_cnt != sync_timeout)
			to_next = to_cnt + 1'b1; // saturates at the timeout
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			to_cnt     <= '0;
			sync_state <= 1'b0;
		end else begin
			to_cnt     <= to_next;
			sync_state <= (role == sync_time_pkg::role_master) ||
				((role == sync_time_pkg::role_slave) && (to_next < sync_timeout));
		end
	end

	// one request per interval, never back to back
	a_send_single: assert property (@(posedge clk) disable iff (rst)
		send_req |=> !send_req);

endmodule

/* logic/sync_rx_parser.sv */
`timescale 1ns/1ps
`include "sync_macros.svh"

module sync_rx_parser (
	input  logic                           clk,
	input  logic                           rst,
	input  sync_time_pkg::role_e           role,
	input  logic [`SYNC_PORT_COUNT-1:0]    rx_req,
	input  sync_frame_pkg::beat_t          rx_beat,
	input  logic [`SYNC_LINK_DELAY_W-1:0]  link_delay,
	input  logic                           tx_busy,
	output logic [`SYNC_PORT_COUNT-1:0]    rx_ack,
	output logic                           rx_done,
	output sync_frame_pkg::sync_fields_t   rx_fields,
	output logic [`SYNC_PORT_COUNT-1:0]    src_mask,
	output sync_time_pkg::time_load_t      time_load
);

	localparam logic [`SYNC_BEAT_CNT_W-1:0] last_beat =
		`SYNC_BEAT_CNT_W'(`SYNC_FRAME_BEATS - 1);
	localparam logic [`SYNC_TIME_W-1:0] fixed_add =
		`SYNC_TIME_W'(`SYNC_RESIDENCE_TICKS * `SYNC_NS_PER_TICK + `SYNC_FIXED_OFFSET_NS);

	sync_frame_pkg::rx_state_e     state;
	logic [`SYNC_BEAT_CNT_W-1:0]   beat_cnt;
	logic [`SYNC_PORT_COUNT-1:0]   grant_pick;
	logic                          src_released;
	logic                          grant_ok;
	logic                          sof_in;
	sync_frame_pkg::sync_fields_t  fields_q;
	logic [`SYNC_TIME_W-1:0]       arrival;
	logic [`SYNC_TIME_W-1:0]       arrival_q;

	assign grant_pick   = rx_req & (~rx_req + 1'b1); // lowest requester
	assign src_released = ((rx_req & src_mask) == '0);
	assign grant_ok     = (role == sync_time_pkg::role_slave) && !tx_busy &&
		(rx_req != '0) && src_released;
	assign sof_in       = rx_beat.wr && (rx_beat.ctrl == `SYNC_CTRL_SOF);

	// origin + correction + link delay + residence + pipeline offset
	assign arrival = fields_q.origin[`SYNC_TIME_W-1:0] + fields_q.correction +
		`SYNC_TIME_W'(link_delay) + fixed_add;

	////////////////////
	// grant and beat FSM
	////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= sync_frame_pkg::rx_idle;
			beat_cnt <= '0;
			rx_ack   <= '0;
			src_mask <= '0;
			rx_done  <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (role != sync_time_pkg::role_slave) begin
				state  <= sync_frame_pkg::rx_idle; // never ack outside slave role
				rx_ack <= '0;
			end else begin
				case (state)
					sync_frame_pkg::rx_idle: begin
						if (grant_ok) begin
							rx_ack   <= grant_pick;
							src_mask <= grant_pick;
							state    <= sync_frame_pkg::rx_granted;
						end
					end
					sync_frame_pkg::rx_granted: begin
						if (sof_in) begin
							beat_cnt <= `SYNC_BEAT_CNT_W'(1);
							state    <= sync_frame_pkg::rx_body;
						end
					end
					sync_frame_pkg::rx_body: begin
						if (rx_beat.wr) begin
							if (beat_cnt == last_beat) begin
								rx_ack <= '0;
								state  <= sync_frame_pkg::rx_compute;
							end else begin
								beat_cnt <= beat_cnt + 1'b1;
							end
						end
					end
					sync_frame_pkg::rx_compute: begin
						rx_done <= 1'b1;
						state   <= sync_frame_pkg::rx_idle;
					end
					default: state <= sync_frame_pkg::rx_idle;
				endcase
			end
		end
	end

	// field extraction at fixed beat positions
	always_ff @(posedge clk) begin
		if (state == sync_frame_pkg::rx_granted && sof_in)
			fields_q.header_stamp <= rx_beat.data;
		if (state == sync_frame_pkg::rx_body && rx_beat.wr) begin
			case (beat_cnt)
				4'd1: begin
					fields_q.mac_d        <= rx_beat.data[63:16];
					fields_q.mac_s[47:32] <= rx_beat.data[15:0];
				end
				4'd2: fields_q.mac_s[31:0]       <= rx_beat.data[63:32];
				4'd3: fields_q.correction[63:48] <= rx_beat.data[15:0];
				4'd4: fields_q.correction[47:0]  <= rx_beat.data[63:16];
				4'd7: fields_q.origin[79:16]     <= rx_beat.data;
				4'd8: begin
					fields_q.origin[15:0] <= rx_beat.data[63:48];
					fields_q.trailer      <= rx_beat.data[47:0];
				end
				default: ; // fixed fields, not stored
			endcase
		end
		if (state == sync_frame_pkg::rx_compute)
			arrival_q <= arrival;
	end

	assign rx_fields       = fields_q;
	assign time_load.valid = rx_done;
	assign time_load.value = arrival_q;

	a_ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(rx_ack));
	a_ack_req: assert property (@(posedge clk) disable iff (rst) (rx_ack & ~rx_req) == '0);

endmodule

/* logic/sync_tx_framer.sv */
`timescale 1ns/1ps
`include "sync_macros.svh"

module sync_tx_framer (
	input  logic                                         clk,
	input  logic                                         rst,
	input  sync_time_pkg::role_e                         role,
	input  logic                                         send_req,
	input  logic                                         rx_done,
	input  sync_frame_pkg::sync_fields_t                 rx_fields,
	input  logic [`SYNC_PORT_COUNT-1:0]                  src_mask,
	input  logic [`SYNC_LINK_DELAY_W-1:0]                link_delay,
	input  logic [`SYNC_TIME_W-1:0]                      local_time,
	input  logic [`SYNC_TIME_W-1:0]                      global_time,
	input  logic [`SYNC_PORT_COUNT-1:0]                  tx_rdy,
	output sync_frame_pkg::beat_t [`SYNC_PORT_COUNT-1:0] tx_beats,
	output logic                                         tx_busy
);

	localparam logic [`SYNC_BEAT_CNT_W-1:0] last_beat =
		`SYNC_BEAT_CNT_W'(`SYNC_FRAME_BEATS - 1);
	localparam logic [79:0] port_id = `SYNC_PORT_IDENTITY;

	sync_frame_pkg::tx_state_e    state;
	logic [`SYNC_BEAT_CNT_W-1:0]  beat_cnt;
	logic                         start;
	logic [`SYNC_PORT_COUNT-1:0]  tgt_next;
	logic [`SYNC_PORT_COUNT-1:0]  tgt_q;
	logic [`SYNC_PORT_COUNT-1:0]  tx_wr;
	sync_frame_pkg::sync_fields_t fields_next;
	sync_frame_pkg::sync_fields_t fields_q;

	// beat layout of the sync frame
	function automatic sync_frame_pkg::beat_t build_beat(
		input sync_frame_pkg::sync_fields_t f,
		input logic [`SYNC_BEAT_CNT_W-1:0]  idx
	);
		sync_frame_pkg::beat_t b;
		b.wr   = 1'b1;
		b.ctrl = '0;
		case (idx)
			4'd0: b.data = f.header_stamp;
			4'd1: b.data = {f.mac_d, f.mac_s[47:32]};
			4'd2: b.data = {f.mac_s[31:0], `SYNC_ETHER_TYPE, 12'h000, `SYNC_PTP_VERSION};
			4'd3: b.data = {`SYNC_MSG_LENGTH, 32'h0, f.correction[63:48]};
			4'd4: b.data = {f.correction[47:0], 16'h0};
			4'd5: b.data = {16'h0, port_id[79:32]};
			4'd6: b.data = {port_id[31:0], 24'h0, `SYNC_LOG_INTERVAL};
			4'd7: b.data = f.origin[79:16];
			default: b.data = {f.origin[15:0], f.trailer};
		endcase
		if (idx == '0)
			b.ctrl = `SYNC_CTRL_SOF;
		else if (idx == last_beat)
			b.ctrl = `SYNC_CTRL_EOF;
		return b;
	endfunction

	assign start = ((role == sync_time_pkg::role_master) && send_req) ||
		((role == sync_time_pkg::role_slave) && rx_done);
	assign tgt_next = (role == sync_time_pkg::role_master) ? '1 : ~src_mask;
	assign tx_busy  = (state != sync_frame_pkg::tx_idle) || start; // blocks a new grant

	////////////////////
	// field selection by role
	////////////////////
	always_comb begin
		fields_next = rx_fields;
		if (role == sync_time_pkg::role_slave) begin
			fields_next.correction = rx_fields.correction + `SYNC_CORR_W'(link_delay);
		end else begin
			fields_next.header_stamp = local_time;
			fields_next.mac_d        = `SYNC_DEF_MAC_D;
			fields_next.mac_s        = `SYNC_DEF_MAC_S;
			fields_next.correction   = '0;
			fields_next.origin       = `SYNC_TS_W'(global_time);
			fields_next.trailer      = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == sync_frame_pkg::tx_idle && start)
			fields_q <= fields_next; // held through back-pressure
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= sync_frame_pkg::tx_idle;
			beat_cnt <= '0;
			tgt_q    <= '0;
			tx_beats <= '0;
		end else begin
			tx_beats <= '0;
			case (state)
				sync_frame_pkg::tx_idle: begin
					if (start) begin
						tgt_q    <= tgt_next;
						beat_cnt <= '0;
						state    <= ((tx_rdy & tgt_next) == tgt_next) ?
							sync_frame_pkg::tx_send : sync_frame_pkg::tx_wait_ready;
					end
				end
				sync_frame_pkg::tx_wait_ready: begin
					if ((tx_rdy & tgt_q) == tgt_q)
						state <= sync_frame_pkg::tx_send;
				end
				sync_frame_pkg::tx_send: begin
					for (int i = 0; i < `SYNC_PORT_COUNT; i++) begin
						if (tgt_q[i])
							tx_beats[i] <= build_beat(fields_q, beat_cnt);
					end
					if (beat_cnt == last_beat)
						state <= sync_frame_pkg::tx_idle;
					else
						beat_cnt <= beat_cnt + 1'b1;
				end
				default: state <= sync_frame_pkg::tx_idle;
			endcase
		end
	end

	for (genvar i = 0; i < `SYNC_PORT_COUNT; i++) begin : g_wr
		assign tx_wr[i] = tx_beats[i].wr;
	end

	// no gaps on any target once a frame is under way
	a_send_contig: assert property (@(posedge clk) disable iff (rst)
		(state == sync_frame_pkg::tx_send) |=> ((tx_wr & tgt_q) == tgt_q));

endmodule

/* logic/sync_time_keeper.sv */
`timescale 1ns/1ps
`include "sync_macros.svh"

module sync_time_keeper (
	input  logic                      clk,
	input  logic                      rst,
	input  sync_time_pkg::time_load_t time_load,
	output logic [`SYNC_TIME_W-1:0]   local_time,
	output logic [`SYNC_TIME_W-1:0]   global_time
);

	localparam logic [`SYNC_TIME_W-1:0] ns_step = `SYNC_TIME_W'(`SYNC_NS_PER_TICK);

	////////////////////
	// free running clock counter
	////////////////////
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			local_time <= '0;
		else
			local_time <= local_time + 1'b1;
	end

	// global time in ns, replaced by the arrival time on a load
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			global_time <= '0;
		else if (time_load.valid)
			global_time <= time_load.value;
		else
			global_time <= global_time + ns_step;
	end

endmodule

/* logic/sync_event_ctrl.sv */
`timescale 1ns/1ps
`include "sync_macros.svh"

module sync_event_ctrl (
	input  logic                                         clk,
	input  logic                                         rst,
	input  logic                                         master_en,
	input  logic                                         slave_en,
	input  logic [`SYNC_PORT_COUNT-1:0]                  rx_req,
	input  sync_frame_pkg::beat_t                        rx_beat,
	input  logic [`SYNC_INTERVAL_W-1:0]                  sync_interval,
	input  logic [`SYNC_TIMEOUT_W-1:0]                   sync_timeout,
	input  logic [`SYNC_LINK_DELAY_W-1:0]                link_delay,
	input  logic [`SYNC_PORT_COUNT-1:0]                  tx_rdy,
	output logic [`SYNC_PORT_COUNT-1:0]                  rx_ack,
	output sync_frame_pkg::beat_t [`SYNC_PORT_COUNT-1:0] tx_beats,
	output logic [`SYNC_TIME_W-1:0]                      local_time,
	output logic [`SYNC_TIME_W-1:0]                      global_time,
	output logic                                         sync_state
);

	sync_time_pkg::role_e         role;
	logic                         send_req;
	logic                         rx_done;
	logic                         tx_busy;
	sync_frame_pkg::sync_fields_t rx_fields;
	logic [`SYNC_PORT_COUNT-1:0]  src_mask;
	sync_time_pkg::time_load_t    time_load;

	// master wins
	assign role = master_en ? sync_time_pkg::role_master :
		slave_en ? sync_time_pkg::role_slave : sync_time_pkg::role_none;

	sync_tick_gen tick0 (
		.clk(clk), .rst(rst), .role(role),
		.sync_interval(sync_interval), .sync_timeout(sync_timeout),
		.rx_done(rx_done), .send_req(send_req), .sync_state(sync_state)
	);

	sync_rx_parser rx0 (
		.clk(clk), .rst(rst), .role(role),
		.rx_req(rx_req), .rx_beat(rx_beat), .link_delay(link_delay), .tx_busy(tx_busy),
		.rx_ack(rx_ack), .rx_done(rx_done), .rx_fields(rx_fields),
		.src_mask(src_mask), .time_load(time_load)
	);

	sync_tx_framer tx0 (
		.clk(clk), .rst(rst), .role(role),
		.send_req(send_req), .rx_done(rx_done), .rx_fields(rx_fields),
		.src_mask(src_mask), .link_delay(link_delay),
		.local_time(local_time), .global_time(global_time), .tx_rdy(tx_rdy),
		.tx_beats(tx_beats), .tx_busy(tx_busy)
	);

	sync_time_keeper time0 (
		.clk(clk), .rst(rst), .time_load(time_load),
		.local_time(local_time), .global_time(global_time)
	);

endmodule

/* verification/sync_event_ctrl_tb.sv */
`timescale 1ns/1ps
`include "sync_macros.svh"

module sync_event_ctrl_tb;

	localparam int rst_cycles   = 5;
	localparam int interval_us  = 2;
	localparam int int_cyc      = interval_us * `SYNC_TICKS_PER_US;
	localparam int timeout_ints = 3;
	localparam int wd_cycles    =
		rst_cycles + 4 * int_cyc + 300 + (timeout_ints + 1) * int_cyc + 600;
	localparam logic [79:0] pid = `SYNC_PORT_IDENTITY;

	logic clk = 1'b0;
	logic rst;
	logic master_en;
	logic slave_en;
	logic [`SYNC_PORT_COUNT-1:0] rx_req;
	sync_frame_pkg::beat_t rx_beat;
	logic [`SYNC_INTERVAL_W-1:0] sync_interval;
	logic [`SYNC_TIMEOUT_W-1:0] sync_timeout;
	logic [`SYNC_LINK_DELAY_W-1:0] link_delay;
	logic [`SYNC_PORT_COUNT-1:0] tx_rdy;
	logic [`SYNC_PORT_COUNT-1:0] rx_ack;
	sync_frame_pkg::beat_t [`SYNC_PORT_COUNT-1:0] tx_beats;
	logic [`SYNC_TIME_W-1:0] local_time;
	logic [`SYNC_TIME_W-1:0] global_time;
	logic sync_state;

	// model state
	logic [63:0] exp_frame [0:8];
	int beat_idx [0:3];
	int eof_count = 0;
	longint cyc = 0;
	longint last_sof = -1;
	logic master_chk = 1'b0;
	logic check_data = 1'b0;
	logic interval_chk = 1'b0;
	logic bp_hold = 1'b0;
	logic slave_chk = 1'b0;
	logic [`SYNC_PORT_COUNT-1:0] tx_wr;
	int error_count = 0;
	integer seed = 55957;

	sync_event_ctrl dut0 (.*);

	always #4 clk = ~clk;
	always @(posedge clk) cyc <= cyc + 1;

	for (genvar g = 0; g < `SYNC_PORT_COUNT; g++) begin : g_wr
		assign tx_wr[g] = tx_beats[g].wr;
	end

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("Fail %s expected %h actual %h", name, exp, act);
		error_count++;
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		error_count++;
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// expected beat data from the sync frame layout
	function automatic logic [63:0] frame_beat(input int idx, input logic [63:0] hs,
		input logic [47:0] md, input logic [47:0] ms, input logic [63:0] corr,
		input logic [79:0] org, input logic [47:0] trl);
		logic [63:0] d;
		case (idx)
			0: d = hs;
			1: d = {md, ms[47:32]};
			2: d = {ms[31:0], 16'h88F7, 12'h000, 4'h2};
			3: d = {16'h002C, 32'h0, corr[63:48]};
			4: d = {corr[47:0], 16'h0};
			5: d = {16'h0, pid[79:32]};
			6: d = {pid[31:0], 24'h0, 8'h7F};
			7: d = org[79:16];
			default: d = {org[15:0], trl};
		endcase
		return d;
	endfunction

	////////////////////
	// frame monitor
	////////////////////
	always @(posedge clk) begin
		if (!rst) begin
			// clock counter runs from the first edge after reset release
			assert (local_time == 64'(cyc - rst_cycles))
			else report_mismatch("local time", 64'(cyc - rst_cycles), local_time);
			for (int p = 0; p < `SYNC_PORT_COUNT; p++) begin
				if (tx_beats[p].wr) begin
					if (p == 0 && beat_idx[0] == 0 && master_chk) begin
						// capture happened two clocks before beat 0
						for (int i = 0; i < 9; i++)
							exp_frame[i] = frame_beat(i, 64'(cyc - rst_cycles - 2),
								48'h011B19000000, 48'h3C970E0F6857, 64'h0,
								{16'h0, global_time - 64'd16}, 48'h0);
						if (interval_chk && last_sof >= 0)
							assert (cyc - last_sof == int_cyc)
							else report_mismatch("master interval", int_cyc, cyc - last_sof);
						last_sof = cyc;
					end
					if (check_data)
						assert (tx_beats[p].data == exp_frame[beat_idx[p]])
						else report_mismatch("frame beat", exp_frame[beat_idx[p]],
							tx_beats[p].data);
					if (p == 0 && beat_idx[0] == 8)
						eof_count++;
					beat_idx[p]++;
				end else begin
					beat_idx[p] = 0;
				end
			end
		end
	end

	for (genvar g = 0; g < `SYNC_PORT_COUNT; g++) begin : g_contig
		a_contig: assert property (@(posedge clk) disable iff (rst)
			(tx_beats[g].wr && tx_beats[g].ctrl == `SYNC_CTRL_SOF) |=>
			(tx_beats[g].wr && tx_beats[g].ctrl == 8'h00) [*7] ##1
			(tx_beats[g].wr && tx_beats[g].ctrl == `SYNC_CTRL_EOF) ##1 !tx_beats[g].wr)
			else report_error("frame is not nine contiguous beats with SOF and EOF");
	end

	a_bp_quiet: assert property (@(posedge clk) disable iff (rst) bp_hold |-> tx_wr == '0)
		else report_error("beats sent while a target port was not ready");
	a_src_quiet: assert property (@(posedge clk) disable iff (rst) slave_chk |-> !tx_wr[2])
		else report_error("frame forwarded back to its source port");
	a_ack_src: assert property (@(posedge clk) disable iff (rst)
		slave_chk |-> (rx_ack & 4'b1011) == '0)
		else report_error("grant given to a port other than the requester");

	task automatic wait_eof(input int target);
		int n;
		n = 0;
		while (eof_count < target) begin
			@(negedge clk);
			n++;
			if (n > 2 * int_cyc + 400)
				report_error("expected frame never finished on port 0");
		end
	endtask

	// four-phase request, grant, nine beats
	task automatic send_frame(input int port, input logic [63:0] beats [0:8]);
		int n;
		n = 0;
		@(posedge clk);
		rx_req[port] <= 1'b1;
		do begin
			@(negedge clk);
			n++;
			if (n > 100)
				report_error("rx_ack never granted");
		end while (!rx_ack[port]);
		for (int i = 0; i < 9; i++) begin
			@(posedge clk);
			rx_beat <= '{data: beats[i], wr: 1'b1,
				ctrl: (i == 0) ? `SYNC_CTRL_SOF : (i == 8) ? `SYNC_CTRL_EOF : 8'h00};
		end
		@(posedge clk);
		rx_beat <= '0;
	endtask

	initial begin
		#(wd_cycles * 8);
		$display("watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		logic [63:0] hs;
		logic [47:0] md;
		logic [47:0] ms;
		logic [63:0] corr;
		logic [79:0] org;
		logic [47:0] trl;
		logic [63:0] sent [0:8];
		logic [63:0] arrival;
		longint t0;
		for (int p = 0; p < 4; p++)
			beat_idx[p] = 0;
		rst <= 1'b1;
		master_en <= 1'b0;
		slave_en <= 1'b0;
		rx_req <= '0;
		rx_beat <= '0;
		sync_interval <= 16'(interval_us);
		sync_timeout <= 16'(timeout_ints);
		link_delay <= 32'($random(seed));
		tx_rdy <= '1;
		repeat (rst_cycles) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!sync_state && global_time == 0)
		else report_mismatch("reset state", 0, {global_time[62:0], sync_state});
		assert (rx_ack == '0 && tx_wr == '0)
		else report_error("rx_ack or tx wr not low after reset");

		////////////////////
		// master frames and interval
		@(posedge clk);
		master_en <= 1'b1;
		master_chk <= 1'b1;
		check_data <= 1'b1;
		interval_chk <= 1'b1;
		wait_eof(3);
		assert (sync_state) else report_mismatch("master sync_state", 1, sync_state);

		// back-pressure on port 1
		@(posedge clk);
		tx_rdy <= 4'b1101;
		bp_hold <= 1'b1;
		check_data <= 1'b0;
		interval_chk <= 1'b0;
		repeat (int_cyc + 50) @(posedge clk);
		tx_rdy <= '1;
		bp_hold <= 1'b0;
		wait_eof(4);

		////////////////////
		// slave timeout, then one frame on port 2
		@(posedge clk);
		master_en <= 1'b0;
		slave_en <= 1'b1;
		master_chk <= 1'b0;
		t0 = cyc;
		do begin
			@(negedge clk);
			if (cyc - t0 > timeout_ints * int_cyc + 2)
				report_error("sync_state did not fall after the slave timeout");
		end while (sync_state);
		assert (cyc - t0 >= (timeout_ints - 1) * int_cyc + 2)
		else report_mismatch("slave timeout", (timeout_ints - 1) * int_cyc + 2, cyc - t0);

		hs = {$random(seed), $random(seed)};
		md = {16'($random(seed)), $random(seed)};
		ms = {16'($random(seed)), $random(seed)};
		corr = {$random(seed), $random(seed)};
		org = {$random(seed), $random(seed), 16'($random(seed))};
		trl = {16'($random(seed)), $random(seed)};
		for (int i = 0; i < 9; i++) begin
			sent[i] = frame_beat(i, hs, md, ms, corr, org, trl);
			exp_frame[i] = frame_beat(i, hs, md, ms, corr + 64'(link_delay), org, trl);
		end
		arrival = org[63:0] + corr + 64'(link_delay) + 64'(690 * 8) + 64'd16;
		@(posedge clk);
		check_data <= 1'b1;
		slave_chk <= 1'b1;
		send_frame(2, sent);
		// last beat accepted at this edge, time loaded two edges later
		repeat (3) @(negedge clk);
		assert (global_time == arrival) else report_mismatch("arrival time", arrival, global_time);
		assert (sync_state) else report_mismatch("slave sync_state", 1, sync_state);
		@(negedge clk);
		assert (global_time == arrival + 8)
		else report_mismatch("time after load", arrival + 8, global_time);
		@(posedge clk);
		rx_req <= '0;
		wait_eof(5);
		repeat (5) @(posedge clk);

		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+logic
logic/sync_frame_pkg.sv
logic/sync_time_pkg.sv
logic/sync_tick_gen.sv
logic/sync_rx_parser.sv
logic/sync_tx_framer.sv
logic/sync_time_keeper.sv
logic/sync_event_ctrl.sv
verification/sync_event_ctrl_tb.sv

/* Makefile */
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module sync_event_ctrl_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vsync_event_ctrl_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
